// ==== source/video_config.svh ====
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// horizontal timing in clocks
`define H_TOTAL          48
`define H_VISIBLE        32
`define H_OFFSET         4
`define H_SYNC_START     36
`define H_SYNC_WIDTH     4

// vertical timing in lines
`define V_LINES          20
`define V_LINES_ADD      21
`define V_VISIBLE        16
`define V_OFFSET         2
`define V_SYNC_START     17
`define V_SYNC_WIDTH     2

// both syncs active low
`define SYNC_ON_POLARITY 0

// frame buffer geometry
`define LINE_LEN         24
`define RAM_WORDS        384
`define RAM_ADDR_BITS    9

// text window, raster columns and rows
`define OSD_X0           8
`define OSD_X1           24
`define OSD_Y0           4
`define OSD_Y1           12
`define OSD_PAD          2
`define OSD_COLS         2
`define OSD_ALPHA        64
`define PLAIN_ALPHA      16

`endif

// ==== source/raster_pkg.sv ====
package raster_pkg;

    // horizontal or vertical counter value
    typedef logic [11:0] coord_t;

    // scan-out sequencing
    typedef enum logic {
        scan_idle,
        scan_run
    } scan_state_t;

endpackage

// ==== source/pixel_pkg.sv ====
`include "video_config.svh"

package pixel_pkg;

    // red in the top byte
    typedef logic [23:0] rgb_t;

    typedef logic [`RAM_ADDR_BITS-1:0] fb_addr_t;

    typedef logic [9:0] text_addr_t;

    // bit 7 carries no glyph information
    typedef logic [7:0] char_code_t;

    // msb is the leftmost pixel
    typedef logic [7:0] glyph_row_t;

endpackage

// ==== source/scan_timing.sv ====
`timescale 1ns/1ps

`include "video_config.svh"

module scan_timing (
    input  logic               clock,
    input  logic               combined_reset,
    input  logic               start_req,
    input  logic               line_doubler,
    input  logic               add_line,
    output logic               start_ack,
    output logic               restart,
    output raster_pkg::coord_t x,
    output raster_pkg::coord_t y,
    output logic               run,
    output logic               hsync_raw,
    output logic               vsync_raw
);
    import raster_pkg::*;

    localparam logic sync_on = 1'(`SYNC_ON_POLARITY);

    scan_state_t state;
    logic        line_doubler_q;
    logic        add_line_q;
    logic        mode_change;
    logic        start_new;
    coord_t      frame_lines;
    logic        hsync_on;
    logic        vsync_on;

    // any edge on a mode input drops back to idle
    assign mode_change = (line_doubler != line_doubler_q) || (add_line != add_line_q);

    // first cycle of a fresh request
    assign start_new = start_req && !start_ack && (state == scan_idle) && !mode_change;

    assign frame_lines = add_line ? coord_t'(`V_LINES_ADD) : coord_t'(`V_LINES);
    assign run = (state == scan_run);

    always_ff @(posedge clock) begin
        line_doubler_q <= line_doubler;
        add_line_q <= add_line;
    end

    // four-phase responder, ack follows req by one cycle
    always_ff @(posedge clock) begin
        if (combined_reset) begin
            start_ack <= 1'b0;
        end else begin
            start_ack <= start_req;
        end
    end

    always_ff @(posedge clock) begin
        if (combined_reset || mode_change) begin
            state <= scan_idle;
            restart <= 1'b0;
            x <= '0;
            y <= '0;
        end else begin
            restart <= start_new;
            if (start_new) begin
                state <= scan_run;
                x <= '0;
                y <= '0;
            end else if (state == scan_run) begin
                if (x == coord_t'(`H_TOTAL - 1)) begin
                    x <= '0;
                    if (y >= frame_lines - 1'b1) begin
                        y <= '0;
                    end else begin
                        y <= y + 1'b1;
                    end
                end else begin
                    x <= x + 1'b1;
                end
            end
        end
    end

    assign hsync_on = (x >= `H_SYNC_START) && (x < `H_SYNC_START + `H_SYNC_WIDTH);

    // vsync edges line up with the hsync start column
    assign vsync_on = ((y == `V_SYNC_START) && (x >= `H_SYNC_START))
                   || ((y > `V_SYNC_START) && (y < `V_SYNC_START + `V_SYNC_WIDTH))
                   || ((y == `V_SYNC_START + `V_SYNC_WIDTH) && (x < `H_SYNC_START));

    always_ff @(posedge clock) begin
        if (combined_reset || !run) begin
            hsync_raw <= ~sync_on;
            vsync_raw <= ~sync_on;
        end else begin
            hsync_raw <= hsync_on ? sync_on : ~sync_on;
            vsync_raw <= vsync_on ? sync_on : ~sync_on;
        end
    end

endmodule

// ==== source/frame_addresser.sv ====
`timescale 1ns/1ps

`include "video_config.svh"

module frame_addresser (
    input  logic                clock,
    input  logic                combined_reset,
    input  raster_pkg::coord_t  x,
    input  raster_pkg::coord_t  y,
    input  logic                run,
    input  logic                line_doubler,
    output pixel_pkg::fb_addr_t rdaddr,
    output raster_pkg::coord_t  x_d,
    output raster_pkg::coord_t  y_d,
    output logic                in_picture
);
    import raster_pkg::*;
    import pixel_pkg::*;

    fb_addr_t row_base;
    coord_t   row_rel;
    logic     row_in_pic;
    logic     pix_in_pic;
    logic     row_step;

    assign row_rel = y - coord_t'(`V_OFFSET);
    assign row_in_pic = (y >= `V_OFFSET) && (y < `V_VISIBLE - `V_OFFSET);
    assign pix_in_pic = run && row_in_pic
                     && (x >= `H_OFFSET) && (x < `H_VISIBLE - `H_OFFSET);

    // doubled rows move on only after the odd line of each pair
    assign row_step = !line_doubler || row_rel[0];

    always_ff @(posedge clock) begin
        if (combined_reset || !run) begin
            row_base <= '0;
        end else if (x == coord_t'(`H_TOTAL - 1)) begin
            if (!row_in_pic) begin
                row_base <= '0;
            end else if (row_step && row_base < `RAM_WORDS - `LINE_LEN) begin
                row_base <= row_base + fb_addr_t'(`LINE_LEN);
            end
        end
    end

    // idle parks the coordinates off screen
    always_ff @(posedge clock) begin
        if (combined_reset) begin
            rdaddr <= '0;
            in_picture <= 1'b0;
            x_d <= coord_t'(`H_TOTAL);
            y_d <= coord_t'(`V_LINES_ADD);
        end else begin
            rdaddr <= pix_in_pic ? fb_addr_t'(row_base + fb_addr_t'(x - coord_t'(`H_OFFSET)))
                                 : '0;
            in_picture <= pix_in_pic;
            x_d <= run ? x : coord_t'(`H_TOTAL);
            y_d <= run ? y : coord_t'(`V_LINES_ADD);
        end
    end

endmodule

// ==== source/osd_overlay.sv ====
`timescale 1ns/1ps

`include "video_config.svh"

module osd_overlay (
    input  logic                   clock,
    input  logic                   combined_reset,
    input  raster_pkg::coord_t     x_d,
    input  raster_pkg::coord_t     y_d,
    input  logic                   enable_osd,
    input  pixel_pkg::char_code_t  text_rddata,
    output pixel_pkg::text_addr_t  text_rdaddr,
    output logic                   in_window,
    output logic                   text_on
);
    import raster_pkg::*;
    import pixel_pkg::*;

    // 128 codes by 8 rows
    glyph_row_t glyph_rom [128][8];

    coord_t     rel_x;
    coord_t     rel_y;
    logic       in_text;
    logic       in_pad;
    logic       text_area_q;
    logic [2:0] glyph_line_q;
    logic [2:0] glyph_col_q;
    glyph_row_t glyph;

    // blocky font: outline rows plus a code-dependent middle
    function automatic glyph_row_t make_glyph(input logic [6:0] code, input logic [2:0] line);
        glyph_row_t row;
        case (line)
            3'd0, 3'd7: row = 8'h00;
            3'd1, 3'd6: row = code[0] ? 8'h7e : 8'h3c;
            default:    row = {2'b01, code[6:3] ^ {line[1:0], line[1:0]}, 2'b10};
        endcase
        return row;
    endfunction

    initial begin
        for (int c = 0; c < 128; c++) begin
            for (int r = 0; r < 8; r++) begin
                glyph_rom[c][r] = make_glyph(7'(c), 3'(r));
            end
        end
    end

    assign rel_x = x_d - coord_t'(`OSD_X0);
    assign rel_y = y_d - coord_t'(`OSD_Y0);

    assign in_text = enable_osd
                  && (x_d >= `OSD_X0) && (x_d < `OSD_X1)
                  && (y_d >= `OSD_Y0) && (y_d < `OSD_Y1);

    assign in_pad = enable_osd
                 && (x_d >= `OSD_X0 - `OSD_PAD) && (x_d < `OSD_X1 + `OSD_PAD)
                 && (y_d >= `OSD_Y0 - `OSD_PAD) && (y_d < `OSD_Y1 + `OSD_PAD);

    // one character cell is 8 by 8
    assign text_rdaddr = in_text ? text_addr_t'((rel_y >> 3) * `OSD_COLS + (rel_x >> 3))
                                 : '0;

    always_ff @(posedge clock) begin
        if (combined_reset) begin
            text_area_q <= 1'b0;
            in_window <= 1'b0;
        end else begin
            text_area_q <= in_text;
            in_window <= in_pad;
        end
    end

    always_ff @(posedge clock) begin
        glyph_line_q <= rel_y[2:0];
        glyph_col_q <= rel_x[2:0];
    end

    // text ram answers one cycle after the address
    assign glyph = glyph_rom[text_rddata[6:0]][glyph_line_q];
    assign text_on = text_area_q && glyph[3'd7 - glyph_col_q];

endmodule

// ==== source/pixel_output.sv ====
`timescale 1ns/1ps

`include "video_config.svh"

module pixel_output (
    input  logic               clock,
    input  logic               combined_reset,
    input  pixel_pkg::rgb_t    rddata,
    input  logic               in_picture,
    input  logic               in_window,
    input  logic               text_on,
    input  logic               hsync_raw,
    input  logic               vsync_raw,
    input  raster_pkg::coord_t x_d,
    input  raster_pkg::coord_t y_d,
    output pixel_pkg::rgb_t    video_out,
    output logic               draw_area,
    output logic               hsync,
    output logic               vsync
);
    import pixel_pkg::*;

    localparam logic sync_on = 1'(`SYNC_ON_POLARITY);

    logic pic_q;
    logic draw_q;
    logic hsync_q;
    logic vsync_q;
    rgb_t pixel;

    // colour * 16 / alpha, low byte kept
    function automatic logic [7:0] dim_channel(input logic [7:0] c, input int unsigned alpha);
        int unsigned scaled;
        scaled = (32'(c) * 16) / alpha;
        return scaled[7:0];
    endfunction

    function automatic rgb_t dim(input rgb_t c, input int unsigned alpha);
        return {dim_channel(c[23:16], alpha), dim_channel(c[15:8], alpha),
                dim_channel(c[7:0], alpha)};
    endfunction

    always_comb begin
        if (!pic_q) begin
            pixel = '0;
        end else if (text_on) begin
            pixel = '1;
        end else if (in_window) begin
            pixel = dim(rddata, `OSD_ALPHA);
        end else begin
            pixel = dim(rddata, `PLAIN_ALPHA);
        end
    end

    // two stages so sync and flags meet the ram data
    always_ff @(posedge clock) begin
        if (combined_reset) begin
            pic_q <= 1'b0;
            draw_q <= 1'b0;
            hsync_q <= ~sync_on;
            vsync_q <= ~sync_on;
            video_out <= '0;
            draw_area <= 1'b0;
            hsync <= ~sync_on;
            vsync <= ~sync_on;
        end else begin
            pic_q <= in_picture;
            draw_q <= (x_d < `H_VISIBLE) && (y_d < `V_VISIBLE);
            hsync_q <= hsync_raw;
            vsync_q <= vsync_raw;
            video_out <= pixel;
            draw_area <= draw_q;
            hsync <= hsync_q;
            vsync <= vsync_q;
        end
    end

endmodule

// ==== source/video_scanout.sv ====
`timescale 1ns/1ps

module video_scanout (
    input  logic                  clock,
    input  logic                  combined_reset,
    input  logic                  start_req,
    output logic                  start_ack,
    input  logic                  line_doubler,
    input  logic                  add_line,
    input  logic                  enable_osd,
    output pixel_pkg::fb_addr_t   rdaddr,
    input  pixel_pkg::rgb_t       rddata,
    output pixel_pkg::text_addr_t text_rdaddr,
    input  pixel_pkg::char_code_t text_rddata,
    output pixel_pkg::rgb_t       video_out,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  draw_area,
    output logic                  restart
);
    import raster_pkg::*;

    coord_t x;
    coord_t y;
    coord_t x_d;
    coord_t y_d;
    logic   run;
    logic   hsync_raw;
    logic   vsync_raw;
    logic   in_picture;
    logic   in_window;
    logic   text_on;

    scan_timing timing0 (
        .clock          (clock),
        .combined_reset (combined_reset),
        .start_req      (start_req),
        .line_doubler   (line_doubler),
        .add_line       (add_line),
        .start_ack      (start_ack),
        .restart        (restart),
        .x              (x),
        .y              (y),
        .run            (run),
        .hsync_raw      (hsync_raw),
        .vsync_raw      (vsync_raw)
    );

    frame_addresser addresser0 (
        .clock          (clock),
        .combined_reset (combined_reset),
        .x              (x),
        .y              (y),
        .run            (run),
        .line_doubler   (line_doubler),
        .rdaddr         (rdaddr),
        .x_d            (x_d),
        .y_d            (y_d),
        .in_picture     (in_picture)
    );

    osd_overlay osd0 (
        .clock          (clock),
        .combined_reset (combined_reset),
        .x_d            (x_d),
        .y_d            (y_d),
        .enable_osd     (enable_osd),
        .text_rddata    (text_rddata),
        .text_rdaddr    (text_rdaddr),
        .in_window      (in_window),
        .text_on        (text_on)
    );

    pixel_output output0 (
        .clock          (clock),
        .combined_reset (combined_reset),
        .rddata         (rddata),
        .in_picture     (in_picture),
        .in_window      (in_window),
        .text_on        (text_on),
        .hsync_raw      (hsync_raw),
        .vsync_raw      (vsync_raw),
        .x_d            (x_d),
        .y_d            (y_d),
        .video_out      (video_out),
        .draw_area      (draw_area),
        .hsync          (hsync),
        .vsync          (vsync)
    );

endmodule

// ==== verification/video_scanout_checker.sv ====
`timescale 1ns/1ps

module video_scanout_checker (
    input logic clock,
    input logic combined_reset,
    input logic start_req,
    input logic start_ack,
    input logic restart,
    input logic hsync,
    input logic vsync
);

    int assert_failures;

    initial assert_failures = 0;

    // ack only ever answers a pending request
    ack_needs_req: assert property (
        @(posedge clock) disable iff (combined_reset)
        $rose(start_ack) |-> $past(start_req)
    ) else begin
        $error("start_ack rose without start_req");
        assert_failures++;
    end

    ack_drops_after_req: assert property (
        @(posedge clock) disable iff (combined_reset)
        $fell(start_ack) |-> !$past(start_req)
    ) else begin
        $error("start_ack fell while start_req was still high");
        assert_failures++;
    end

    restart_with_ack: assert property (
        @(posedge clock) disable iff (combined_reset)
        restart |-> start_ack
    ) else begin
        $error("restart pulse without start_ack");
        assert_failures++;
    end

    // vsync edges share the hsync start column
    vsync_on_hsync: assert property (
        @(posedge clock) disable iff (combined_reset)
        $fell(vsync) |-> $fell(hsync)
    ) else begin
        $error("vsync started away from an hsync start");
        assert_failures++;
    end

    hsync_released: assert property (
        @(posedge clock) disable iff (combined_reset)
        $fell(hsync) |-> ##4 hsync
    ) else begin
        $error("hsync pulse longer than the sync width");
        assert_failures++;
    end

endmodule

// ==== verification/video_scanout_monitor.sv ====
`timescale 1ns/1ps

`include "video_config.svh"

module video_scanout_monitor (
    input  logic            clock,
    input  logic            combined_reset,
    input  logic            start_req,
    input  logic            start_ack,
    input  logic            line_doubler,
    input  logic            add_line,
    input  logic            enable_osd,
    input  pixel_pkg::rgb_t video_out,
    input  logic            hsync,
    input  logic            vsync,
    input  logic            draw_area,
    input  logic            restart,
    input  int              expected_lines,
    input  int              test_id,
    input  logic            test_done,
    output int              error_count,
    output int              check_count
);
    import pixel_pkg::*;

    // stage 0 holds the current position and stage 3 the one on the outputs
    logic v [4];
    int   px [4];
    int   py [4];
    logic pld [4];
    logic posd [4];
    logic ld_p1;
    logic ld_p2;
    logic al_p1;
    logic al_p2;
    logic req_p1;
    logic ack_p1;
    logic hs_p1;
    logic vs_p1;
    int   since_hs;
    int   lines;
    logic seen_vs;
    int   errors_at_start;

    function automatic logic [7:0] font_row(input logic [6:0] code, input int line);
        logic [1:0] l;
        l = line[1:0];
        if (line == 0 || line == 7)
            return 8'h00;
        if (line == 1 || line == 6)
            return code[0] ? 8'h7e : 8'h3c;
        return {2'b01, code[6:3] ^ {l, l}, 2'b10};
    endfunction

    function automatic rgb_t dimmed(input rgb_t c);
        int r;
        int g;
        int b;
        r = 32'(c[23:16]) * 16 / `OSD_ALPHA;
        g = 32'(c[15:8]) * 16 / `OSD_ALPHA;
        b = 32'(c[7:0]) * 16 / `OSD_ALPHA;
        return {r[7:0], g[7:0], b[7:0]};
    endfunction

    function automatic rgb_t expected_pixel(input int x, input int y, input logic ld,
                                            input logic osd);
        int         row;
        int         tx;
        int         ty;
        rgb_t       c;
        logic [7:0] code;
        logic [7:0] grow;
        if (x < `H_OFFSET || x >= `H_VISIBLE - `H_OFFSET
                || y < `V_OFFSET || y >= `V_VISIBLE - `V_OFFSET)
            return '0;
        row = ld ? (y - `V_OFFSET) / 2 : y - `V_OFFSET;
        c = video_scanout_tb.frame_mem[row * `LINE_LEN + x - `H_OFFSET];
        if (osd && x >= `OSD_X0 && x < `OSD_X1 && y >= `OSD_Y0 && y < `OSD_Y1) begin
            tx = x - `OSD_X0;
            ty = y - `OSD_Y0;
            code = video_scanout_tb.text_mem[(ty / 8) * `OSD_COLS + tx / 8];
            grow = font_row(code[6:0], ty % 8);
            if (grow[7 - tx % 8])
                return 24'hffffff;
        end
        if (osd && x >= `OSD_X0 - `OSD_PAD && x < `OSD_X1 + `OSD_PAD
                && y >= `OSD_Y0 - `OSD_PAD && y < `OSD_Y1 + `OSD_PAD)
            return dimmed(c);
        return c;
    endfunction

    task automatic mismatch(input string name, input int x, input int y,
                            input logic [23:0] got, input logic [23:0] exp);
        $display("mismatch %s at x=%0d y=%0d: got %h expected %h", name, x, y, got, exp);
        error_count++;
    endtask

    task automatic failure(input string what);
        $display("error: %s", what);
        error_count++;
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        errors_at_start = 0;
    end

    always @(posedge clock) begin
        logic cont;
        logic hs_fall;
        logic vs_fall;
        int   nx;
        int   ny;
        int   x3;
        int   y3;
        int   pos3;
        logic exp_hs;
        logic exp_vs;
        logic exp_draw;
        rgb_t exp_pix;
        if (combined_reset) begin
            for (int i = 0; i < 4; i++)
                v[i] = 1'b0;
            ld_p1 = line_doubler;
            ld_p2 = line_doubler;
            al_p1 = add_line;
            al_p2 = add_line;
            req_p1 = start_req;
            ack_p1 = 1'b0;
            hs_p1 = 1'b1;
            vs_p1 = 1'b1;
            since_hs = -1;
            lines = 0;
            seen_vs = 1'b0;
        end else begin
            // a mode edge in the last cycle ends the run
            cont = v[0] && ld_p1 == ld_p2 && al_p1 == al_p2;
            nx = 0;
            ny = 0;
            if (restart && cont)
                failure("restart while a frame was running");
            if (restart && !(req_p1 && !ack_p1))
                failure("restart without a fresh start request");
            if (start_ack !== req_p1)
                mismatch("start_ack", px[0], py[0], start_ack, req_p1);
            if (!restart && cont) begin
                nx = (px[0] == `H_TOTAL - 1) ? 0 : px[0] + 1;
                ny = py[0];
                if (px[0] == `H_TOTAL - 1)
                    ny = (py[0] >= (al_p1 ? `V_LINES_ADD : `V_LINES) - 1) ? 0 : py[0] + 1;
            end
            for (int i = 3; i > 0; i--) begin
                v[i] = v[i-1];
                px[i] = px[i-1];
                py[i] = py[i-1];
                pld[i] = pld[i-1];
                posd[i] = posd[i-1];
            end
            v[0] = restart || cont;
            px[0] = nx;
            py[0] = ny;
            pld[0] = line_doubler;
            posd[1] = enable_osd;

            x3 = px[3];
            y3 = py[3];
            // vsync spans from the hsync start of its first line to that of the line after
            pos3 = y3 * `H_TOTAL + x3;
            exp_draw = v[3] && x3 < `H_VISIBLE && y3 < `V_VISIBLE;
            exp_hs = !(v[3] && x3 >= `H_SYNC_START && x3 < `H_SYNC_START + `H_SYNC_WIDTH);
            exp_vs = !(v[3] && pos3 >= `V_SYNC_START * `H_TOTAL + `H_SYNC_START
                       && pos3 < (`V_SYNC_START + `V_SYNC_WIDTH) * `H_TOTAL + `H_SYNC_START);
            exp_pix = v[3] ? expected_pixel(x3, y3, pld[3], posd[3]) : '0;
            check_count++;
            if (video_out !== exp_pix)
                mismatch("video_out", x3, y3, video_out, exp_pix);
            if (draw_area !== exp_draw)
                mismatch("draw_area", x3, y3, draw_area, exp_draw);
            if (hsync !== exp_hs)
                mismatch("hsync", x3, y3, hsync, exp_hs);
            if (vsync !== exp_vs)
                mismatch("vsync", x3, y3, vsync, exp_vs);

            hs_fall = hs_p1 && !hsync;
            vs_fall = vs_p1 && !vsync;
            if (!v[3]) begin
                since_hs = -1;
                seen_vs = 1'b0;
            end else begin
                if (since_hs >= 0)
                    since_hs++;
                if (hs_fall) begin
                    if (since_hs > 0 && since_hs != `H_TOTAL)
                        failure($sformatf("hsync period was %0d cycles", since_hs));
                    since_hs = 0;
                end
                if (vs_fall) begin
                    if (seen_vs && lines != expected_lines)
                        failure($sformatf("frame had %0d lines instead of %0d",
                                          lines, expected_lines));
                    lines = 0;
                    seen_vs = 1'b1;
                end
                if (hs_fall)
                    lines++;
            end

            if (test_done) begin
                $display("test %0d finished with %0d errors", test_id,
                         error_count - errors_at_start);
                errors_at_start = error_count;
            end
            ld_p2 = ld_p1;
            ld_p1 = line_doubler;
            al_p2 = al_p1;
            al_p1 = add_line;
            req_p1 = start_req;
            ack_p1 = start_ack;
            hs_p1 = hsync;
            vs_p1 = vsync;
        end
    end

endmodule

// ==== verification/video_scanout_tb.sv ====
`timescale 1ns/1ps

`include "video_config.svh"

module video_scanout_tb;
    import pixel_pkg::*;

    typedef struct packed {
        logic       ld;
        logic       al;
        logic       osd;
        logic       toggle;
        logic [7:0] frames;
        logic [7:0] lines;
    } test_t;

    logic       clock;
    logic       combined_reset;
    logic       start_req;
    logic       start_ack;
    logic       line_doubler;
    logic       add_line;
    logic       enable_osd;
    fb_addr_t   rdaddr;
    rgb_t       rddata;
    text_addr_t text_rdaddr;
    char_code_t text_rddata;
    rgb_t       video_out;
    logic       hsync;
    logic       vsync;
    logic       draw_area;
    logic       restart;
    int         expected_lines;
    int         test_id;
    logic       test_done;
    int         error_count;
    int         check_count;
    int         timeouts;

    rgb_t       frame_mem [0:`RAM_WORDS-1];
    char_code_t text_mem [0:15];
    test_t      tests [6];

    video_scanout dut0 (.*);

    video_scanout_monitor mon0 (.*);

    bind video_scanout video_scanout_checker checker0 (
        .clock          (clock),
        .combined_reset (combined_reset),
        .start_req      (start_req),
        .start_ack      (start_ack),
        .restart        (restart),
        .hsync          (hsync),
        .vsync          (vsync)
    );

    always #2 clock = ~clock;

    // both rams answer one cycle after the address
    always @(posedge clock) begin
        rddata <= frame_mem[rdaddr];
        text_rddata <= text_mem[text_rdaddr[3:0]];
    end

    task automatic timed_out(input string what);
        $display("error: timed out waiting for %s", what);
        timeouts++;
    endtask

    task automatic handshake();
        int n;
        @(negedge clock) start_req = 1'b1;
        n = 0;
        while (!start_ack && n < 20) begin
            @(negedge clock);
            n++;
        end
        if (!start_ack)
            timed_out("start_ack to rise");
        start_req = 1'b0;
        n = 0;
        while (start_ack && n < 20) begin
            @(negedge clock);
            n++;
        end
        if (start_ack)
            timed_out("start_ack to fall");
    endtask

    task automatic wait_vsync_starts(input int count);
        int   seen;
        int   n;
        logic prev;
        seen = 0;
        n = 0;
        prev = vsync;
        while (seen < count && n < count * 2 * `H_TOTAL * `V_LINES_ADD) begin
            @(negedge clock);
            if (prev && !vsync)
                seen++;
            prev = vsync;
            n++;
        end
        if (seen < count)
            timed_out("vsync");
    endtask

    task automatic wait_draw_area();
        int n;
        n = 0;
        while (!draw_area && n < 2 * `H_TOTAL * `V_LINES_ADD) begin
            @(negedge clock);
            n++;
        end
        if (!draw_area)
            timed_out("draw_area");
    endtask

    task automatic run_test(input int i);
        @(negedge clock);
        line_doubler = tests[i].ld;
        add_line = tests[i].al;
        enable_osd = tests[i].osd;
        expected_lines = tests[i].lines;
        test_id = i;
        repeat (4) @(negedge clock);
        handshake();
        if (tests[i].toggle) begin
            wait_vsync_starts(1);
            wait_draw_area();
            // several lines into the picture
            repeat (5 * `H_TOTAL) @(negedge clock);
            add_line = ~add_line;
            repeat (300) @(negedge clock);
        end else begin
            wait_vsync_starts(tests[i].frames + 1);
            // a request mid-frame must not restart
            handshake();
            repeat (2 * `H_TOTAL) @(negedge clock);
        end
        @(negedge clock) test_done = 1'b1;
        @(negedge clock) test_done = 1'b0;
    endtask

    initial begin
        clock = 1'b0;
        combined_reset = 1'b1;
        start_req = 1'b0;
        line_doubler = 1'b0;
        add_line = 1'b0;
        enable_osd = 1'b0;
        rddata = '0;
        text_rddata = '0;
        expected_lines = `V_LINES;
        test_id = 0;
        test_done = 1'b0;
        timeouts = 0;
        void'($urandom(32'hedc2));

        //          ld    al    osd   toggle frames lines
        tests[0] = {1'b0, 1'b0, 1'b0, 1'b0, 8'd2, 8'd20};
        tests[1] = {1'b1, 1'b0, 1'b0, 1'b0, 8'd2, 8'd20};
        tests[2] = {1'b0, 1'b0, 1'b1, 1'b0, 8'd2, 8'd20};
        tests[3] = {1'b1, 1'b0, 1'b0, 1'b1, 8'd1, 8'd20};
        tests[4] = {1'b0, 1'b1, 1'b0, 1'b0, 8'd2, 8'd21};
        tests[5] = {1'b1, 1'b1, 1'b1, 1'b0, 8'd2, 8'd21};

        for (int n = 0; n < `RAM_WORDS; n++)
            frame_mem[n] = {8'(n), 8'(n >> 1) ^ 8'ha5, 8'(n * 3) ^ {7'd0, n[8]}};
        // printable ascii only
        for (int n = 0; n < 16; n++)
            text_mem[n] = 8'h20 + 8'($urandom % 95);

        repeat (4) @(posedge clock);
        @(negedge clock) combined_reset = 1'b0;
        // idle without a request
        repeat (60) @(negedge clock);

        for (int i = 0; i < 6; i++)
            run_test(i);

        repeat (4) @(negedge clock);
        $display("tests 6, checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 check_count, error_count, timeouts, dut0.checker0.assert_failures);
        if (error_count == 0 && timeouts == 0 && dut0.checker0.assert_failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+source
source/raster_pkg.sv
source/pixel_pkg.sv
source/scan_timing.sv
source/frame_addresser.sv
source/osd_overlay.sv
source/pixel_output.sv
source/video_scanout.sv
verification/video_scanout_checker.sv
verification/video_scanout_monitor.sv
verification/video_scanout_tb.sv

// ==== Bender.yml ====
package:
  name: video_scanout

sources:
  - include_dirs:
      - source
    files:
      - source/raster_pkg.sv
      - source/pixel_pkg.sv
      - source/scan_timing.sv
      - source/frame_addresser.sv
      - source/osd_overlay.sv
      - source/pixel_output.sv
      - source/video_scanout.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/video_scanout_checker.sv
      - verification/video_scanout_monitor.sv
      - verification/video_scanout_tb.sv
